/* verilog/rv_mem_pkg.sv */
`default_nettype none

package rv_mem_pkg;

    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_num_t;  // Larger is younger
    typedef logic [2:0]  funct3_t;

    // funct3 of LB/LH/LW and SB/SH/SW
    typedef enum logic [2:0] {
        SIZE_B = 3'd0,
        SIZE_H = 3'd1,
        SIZE_W = 3'd2
    } mem_size_e;

endpackage

`default_nettype wire

/* verilog/sb_pkg.sv */
`default_nettype none

package sb_pkg;

    typedef logic [7:0] phy_t;
    typedef logic [3:0] byte_mask_t;

    // Stores have no destination register
    localparam phy_t NO_DEST_PHY = 8'd160;

    typedef struct packed {
        logic                  is_store;
        logic                  is_load;
        rv_mem_pkg::mem_size_e size;
        rv_mem_pkg::addr_t     addr;
        rv_mem_pkg::inst_num_t inst_num;
        phy_t                  phy;
        byte_mask_t            mask;
        rv_mem_pkg::word_t     data;   // Stored bytes only, low aligned
    } mem_req_t;

    // How much of the requested width the buffer covers
    typedef enum logic [2:0] {
        COV_MISS   = 3'b000,
        COV_B_OF_H = 3'b001,
        COV_B_OF_W = 3'b010,
        COV_H_OF_W = 3'b011,
        COV_FULL   = 3'b111
    } fwd_cover_e;

    typedef struct packed {
        logic              hit;
        logic              younger;  // Entry younger than the request
        byte_mask_t        mask;
        rv_mem_pkg::word_t data;
    } fwd_t;

endpackage

`default_nettype wire

/* verilog/mem_req_decode.sv */
`default_nettype none

module mem_req_decode (
    input  logic                  memwrite,
    input  logic                  memread,
    input  rv_mem_pkg::funct3_t   funct3,
    input  rv_mem_pkg::addr_t     mem_addr,
    input  rv_mem_pkg::word_t     mem_data,
    input  rv_mem_pkg::inst_num_t inst_num,
    input  sb_pkg::phy_t          load_phy,
    output sb_pkg::mem_req_t      req
);
    import rv_mem_pkg::*;
    import sb_pkg::*;

    mem_size_e  size;
    byte_mask_t mask;
    word_t      keep;

    always_comb begin
        case (funct3)
            3'd0:    size = SIZE_B;
            3'd1:    size = SIZE_H;
            default: size = SIZE_W;
        endcase

        case (size)
            SIZE_B:  mask = 4'b0001;
            SIZE_H:  mask = 4'b0011;
            default: mask = 4'b1111;
        endcase

        for (int b = 0; b < 4; b++) begin
            keep[8*b +: 8] = {8{mask[b]}};
        end
    end

    always_comb begin
        req.is_store = memwrite;
        req.is_load  = memread && !memwrite;  // Store wins the cycle
        req.size     = size;
        req.addr     = mem_addr;
        req.inst_num = inst_num;
        req.phy      = load_phy;
        req.mask     = mask;
        req.data     = mem_data & keep;
    end

    // Unsigned loads and wider sizes are not handled here
    always_comb begin
        if (memwrite || memread) begin
            a_legal_size: assert final (funct3 <= 3'd2)
                else $error("illegal funct3 %0d on memory request", funct3);
        end
    end

endmodule

`default_nettype wire

/* verilog/store_buffer.sv */
`default_nettype none

module store_buffer #(
    parameter int SB_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  sb_pkg::mem_req_t      req,
    input  logic                  memwrite_rob,
    input  rv_mem_pkg::addr_t     mem_addr_rob,
    input  rv_mem_pkg::inst_num_t inst_num_rob,
    output sb_pkg::fwd_t          fwd,
    output logic                  sb_full
);
    import rv_mem_pkg::*;
    import sb_pkg::*;

    localparam int IDX_W = $clog2(SB_DEPTH);

    logic [SB_DEPTH-1:0] entry_val;
    addr_t               entry_addr [SB_DEPTH];
    inst_num_t           entry_inst [SB_DEPTH];
    byte_mask_t          entry_mask [SB_DEPTH];
    word_t               entry_data [SB_DEPTH];

    logic [SB_DEPTH-1:0] addr_match;
    logic [IDX_W-1:0]    match_idx;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    wr_idx;
    logic                match_any;
    logic                req_wins;
    byte_mask_t          base_mask;
    word_t               base_data;
    byte_mask_t          wr_mask;
    word_t               wr_data;
    inst_num_t           wr_inst;
    logic                dup_addr;

    // Lowest index wins for both searches
    always_comb begin
        match_idx = '0;
        free_idx  = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            addr_match[i] = entry_val[i] && (entry_addr[i] == req.addr);
            if (addr_match[i])
                match_idx = IDX_W'(i);
            if (!entry_val[i])
                free_idx = IDX_W'(i);
        end
    end

    assign match_any = |addr_match;
    assign sb_full   = &entry_val;
    assign wr_idx    = match_any ? match_idx : free_idx;

    // Merge the request into the matching entry, younger bytes win
    always_comb begin
        req_wins  = !match_any || (req.inst_num >= entry_inst[match_idx]);
        base_mask = match_any ? entry_mask[match_idx] : '0;
        base_data = match_any ? entry_data[match_idx] : '0;
        wr_mask   = base_mask | req.mask;
        wr_inst   = req_wins ? req.inst_num : entry_inst[match_idx];
        for (int b = 0; b < 4; b++) begin
            if (req.mask[b] && (!base_mask[b] || req_wins))
                wr_data[8*b +: 8] = req.data[8*b +: 8];
            else
                wr_data[8*b +: 8] = base_data[8*b +: 8];
        end
    end

    always_comb begin
        fwd.hit     = match_any;
        fwd.younger = entry_inst[match_idx] > req.inst_num;
        fwd.mask    = entry_mask[match_idx];
        fwd.data    = entry_data[match_idx];
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            entry_val <= '0;
        end else begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                if (memwrite_rob && entry_val[i] && (entry_addr[i] == mem_addr_rob)
                        && (entry_inst[i] == inst_num_rob))
                    entry_val[i] <= 1'b0;  // Committed
            end
            if (req.is_store)
                entry_val[wr_idx] <= 1'b1;  // Overrides a same-cycle commit
        end
    end

    always_ff @(posedge clk) begin
        if (req.is_store) begin
            entry_addr[wr_idx] <= req.addr;
            entry_inst[wr_idx] <= wr_inst;
            entry_mask[wr_idx] <= wr_mask;
            entry_data[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        dup_addr = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            for (int j = i + 1; j < SB_DEPTH; j++) begin
                if (entry_val[i] && entry_val[j] && (entry_addr[i] == entry_addr[j]))
                    dup_addr = 1'b1;
            end
        end
    end

    a_unique_addr: assert property (@(posedge clk) disable iff (reset) !dup_addr)
        else $error("two valid store buffer entries share an address");

    a_no_store_when_full: assert property (
        @(posedge clk) disable iff (reset) req.is_store |-> !sb_full)
        else $error("store accepted while store buffer is full");

endmodule

`default_nettype wire

/* verilog/load_result.sv */
`default_nettype none

module load_result (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  sb_pkg::mem_req_t      req,
    input  sb_pkg::fwd_t          fwd,
    output rv_mem_pkg::word_t     load_data,
    output sb_pkg::fwd_cover_e    load_valid,
    output sb_pkg::phy_t          load_phy_out,
    output rv_mem_pkg::inst_num_t inst_num_out,
    output logic                  load_done_out,
    output logic                  exception_flag
);
    import rv_mem_pkg::*;
    import sb_pkg::*;

    fwd_cover_e cov_code;
    word_t      ext_data;

    always_comb begin
        if (!fwd.hit)
            cov_code = COV_MISS;
        else if ((fwd.mask & req.mask) == req.mask)
            cov_code = COV_FULL;
        else if (req.size == SIZE_H)
            cov_code = COV_B_OF_H;
        else if (fwd.mask[1])
            cov_code = COV_H_OF_W;
        else
            cov_code = COV_B_OF_W;
    end

    always_comb begin
        if (!fwd.hit)
            ext_data = '0;
        else begin
            case (req.size)
                SIZE_B:  ext_data = {{24{fwd.data[7]}}, fwd.data[7:0]};
                SIZE_H:  ext_data = {{16{fwd.data[15]}}, fwd.data[15:0]};
                default: ext_data = fwd.data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            load_data      <= '0;
            load_valid     <= COV_MISS;
            load_phy_out   <= '0;
            inst_num_out   <= '0;
            load_done_out  <= 1'b0;
            exception_flag <= 1'b0;
        end else begin
            load_done_out <= req.is_load;  // One-cycle pulse
            if (req.is_store) begin
                load_phy_out <= NO_DEST_PHY;
                inst_num_out <= req.inst_num;
            end else if (req.is_load) begin
                load_data    <= ext_data;
                load_valid   <= cov_code;
                load_phy_out <= req.phy;
                inst_num_out <= req.inst_num;
                if (fwd.hit && fwd.younger)
                    exception_flag <= 1'b1;  // Sticky until flush
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_store_top.sv */
`default_nettype none

module lsu_store_top #(
    parameter int SB_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exception,
    input  logic                  mret_sig,
    input  logic                  memwrite,
    input  logic                  memread,
    input  rv_mem_pkg::funct3_t   funct3,
    input  sb_pkg::phy_t          load_phy,
    input  rv_mem_pkg::inst_num_t inst_num,
    input  rv_mem_pkg::addr_t     mem_addr,
    input  rv_mem_pkg::word_t     mem_data,
    input  logic                  memwrite_rob,
    input  rv_mem_pkg::addr_t     mem_addr_rob,
    input  rv_mem_pkg::inst_num_t inst_num_rob,
    output rv_mem_pkg::word_t     load_data,
    output sb_pkg::fwd_cover_e    load_valid,
    output sb_pkg::phy_t          load_phy_out,
    output rv_mem_pkg::inst_num_t inst_num_out,
    output logic                  load_done_out,
    output logic                  exception_flag,
    output logic                  sb_full
);
    import sb_pkg::*;

    mem_req_t req;
    fwd_t     fwd;
    logic     flush;

    assign flush = exception || mret_sig;

    mem_req_decode u_decode (
        .memwrite (memwrite),
        .memread  (memread),
        .funct3   (funct3),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .inst_num (inst_num),
        .load_phy (load_phy),
        .req      (req)
    );

    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) u_store_buffer (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .req          (req),
        .memwrite_rob (memwrite_rob),
        .mem_addr_rob (mem_addr_rob),
        .inst_num_rob (inst_num_rob),
        .fwd          (fwd),
        .sb_full      (sb_full)
    );

    load_result u_load_result (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .req            (req),
        .fwd            (fwd),
        .load_data      (load_data),
        .load_valid     (load_valid),
        .load_phy_out   (load_phy_out),
        .inst_num_out   (inst_num_out),
        .load_done_out  (load_done_out),
        .exception_flag (exception_flag)
    );

endmodule

`default_nettype wire

/* verification/tb_store_buffer.sv */
`default_nettype none

module tb_store_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_mem_pkg::*;
    import sb_pkg::*;

    localparam int DEPTH = 8;

    // Expected outputs, taken over at the edge that samples the request
    typedef struct packed {
        word_t      data;
        fwd_cover_e cov;
        phy_t       phy;
        inst_num_t  inst;
        logic       flag;
        logic       full;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      exception;
    logic      mret_sig;
    logic      memwrite;
    logic      memread;
    funct3_t   funct3;
    phy_t      load_phy;
    inst_num_t inst_num;
    addr_t     mem_addr;
    word_t     mem_data;
    logic      memwrite_rob;
    addr_t     mem_addr_rob;
    inst_num_t inst_num_rob;

    word_t      load_data;
    fwd_cover_e load_valid;
    phy_t       load_phy_out;
    inst_num_t  inst_num_out;
    logic       load_done_out;
    logic       exception_flag;
    logic       sb_full;

    expect_t    exp_next;
    expect_t    exp_q;
    word_t      model_data [addr_t];  // Reference bytes per address
    byte_mask_t model_mask [addr_t];
    inst_num_t  model_inst [addr_t];
    int         errors;
    int         errors_before;
    int         tests_run;
    int         tests_failed;
    int         seed;

    lsu_store_top #(
        .SB_DEPTH (DEPTH)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .exception      (exception),
        .mret_sig       (mret_sig),
        .memwrite       (memwrite),
        .memread        (memread),
        .funct3         (funct3),
        .load_phy       (load_phy),
        .inst_num       (inst_num),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .memwrite_rob   (memwrite_rob),
        .mem_addr_rob   (mem_addr_rob),
        .inst_num_rob   (inst_num_rob),
        .load_data      (load_data),
        .load_valid     (load_valid),
        .load_phy_out   (load_phy_out),
        .inst_num_out   (inst_num_out),
        .load_done_out  (load_done_out),
        .exception_flag (exception_flag),
        .sb_full        (sb_full)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        exp_q <= exp_next;
    end

    a_load_done: assert property (@(posedge clk) disable iff (reset)
        load_done_out == $past(memread && !memwrite))
        else begin
            errors++;
            $display("mismatch load_done_out: got %h expected %h",
                     $sampled(load_done_out), $past(memread && !memwrite));
        end

    a_load_data: assert property (@(posedge clk) disable iff (reset)
        (memread && !memwrite) |=> load_data == exp_q.data)
        else begin
            errors++;
            $display("mismatch load_data: got %h expected %h",
                     $sampled(load_data), $sampled(exp_q.data));
        end

    a_load_valid: assert property (@(posedge clk) disable iff (reset)
        (memread && !memwrite) |=> load_valid == exp_q.cov)
        else begin
            errors++;
            $display("mismatch load_valid: got %h expected %h",
                     $sampled(load_valid), $sampled(exp_q.cov));
        end

    a_phy_out: assert property (@(posedge clk) disable iff (reset)
        (memread || memwrite) |=> load_phy_out == exp_q.phy)
        else begin
            errors++;
            $display("mismatch load_phy_out: got %h expected %h",
                     $sampled(load_phy_out), $sampled(exp_q.phy));
        end

    a_inst_out: assert property (@(posedge clk) disable iff (reset)
        (memread || memwrite) |=> inst_num_out == exp_q.inst)
        else begin
            errors++;
            $display("mismatch inst_num_out: got %h expected %h",
                     $sampled(inst_num_out), $sampled(exp_q.inst));
        end

    a_flag: assert property (@(posedge clk) disable iff (reset)
        exception_flag == exp_q.flag)
        else begin
            errors++;
            $display("mismatch exception_flag: got %h expected %h",
                     $sampled(exception_flag), $sampled(exp_q.flag));
        end

    a_full: assert property (@(posedge clk) disable iff (reset) sb_full == exp_q.full)
        else begin
            errors++;
            $display("mismatch sb_full: got %h expected %h",
                     $sampled(sb_full), $sampled(exp_q.full));
        end

    a_cleared: assert property (@(posedge clk) (reset || exception || mret_sig) |=>
        (load_data == '0 && load_valid == COV_MISS && load_phy_out == '0
         && !load_done_out && !exception_flag && !sb_full))
        else begin
            errors++;
            $display("outputs were not cleared after a reset or flush");
        end

    function automatic byte_mask_t size_mask(funct3_t f);
        case (f)
            3'd0:    return 4'b0001;
            3'd1:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t byte_keep(byte_mask_t m);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = m[b] ? 8'hFF : 8'h00;
        end
        return w;
    endfunction

    // Younger request bytes win on overlap, entry keeps the larger number
    task automatic model_store(input addr_t a, input funct3_t f, input word_t d,
                               input inst_num_t n);
        byte_mask_t m;
        word_t      w;
        byte_mask_t old_m;
        inst_num_t  old_n;
        logic       req_young;
        m     = size_mask(f);
        w     = '0;
        old_m = '0;
        old_n = '0;
        if (model_mask.exists(a)) begin
            w     = model_data[a];
            old_m = model_mask[a];
            old_n = model_inst[a];
        end
        req_young = !model_mask.exists(a) || (n >= old_n);
        for (int b = 0; b < 4; b++) begin
            if (m[b] && (req_young || !old_m[b]))
                w[8*b +: 8] = d[8*b +: 8];
        end
        model_data[a] = w;
        model_mask[a] = old_m | m;
        model_inst[a] = req_young ? n : old_n;
    endtask

    task automatic predict_load(input addr_t a, input funct3_t f, input inst_num_t n);
        byte_mask_t need;
        byte_mask_t have;
        word_t      raw;
        int         nb;
        need = size_mask(f);
        exp_next.data = '0;
        exp_next.cov  = COV_MISS;
        if (model_mask.exists(a)) begin
            have = model_mask[a] & need;
            raw  = model_data[a];
            nb   = 0;
            while (nb < 4 && have[nb])
                nb++;  // Covered low bytes
            case (f)
                3'd0:    exp_next.data = {{24{raw[7]}}, raw[7:0]};
                3'd1:    exp_next.data = {{16{raw[15]}}, raw[15:0]};
                default: exp_next.data = raw;
            endcase
            if (have == need)
                exp_next.cov = COV_FULL;
            else if (f == 3'd1)
                exp_next.cov = COV_B_OF_H;
            else if (nb == 2)
                exp_next.cov = COV_H_OF_W;
            else
                exp_next.cov = COV_B_OF_W;
            if (model_inst[a] > n)
                exp_next.flag = 1'b1;  // Load is older than the store
        end
    endtask

    task automatic store_op(input addr_t a, input funct3_t f, input word_t d,
                            input inst_num_t n);
        int waited;
        memwrite = 1'b1;
        funct3   = f;
        mem_addr = a;
        mem_data = d;
        inst_num = n;
        model_store(a, f, d & byte_keep(size_mask(f)), n);
        exp_next.phy  = NO_DEST_PHY;
        exp_next.inst = n;
        exp_next.full = (model_mask.num() == DEPTH);
        @(posedge clk);
        #1;
        memwrite = 1'b0;
        waited   = 0;
        while (load_phy_out != NO_DEST_PHY && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (load_phy_out != NO_DEST_PHY) begin
            errors++;
            $display("timeout waiting for the store to %h to show on load_phy_out", a);
        end
    endtask

    task automatic load_op(input addr_t a, input funct3_t f, input inst_num_t n,
                           input phy_t p);
        int waited;
        memread  = 1'b1;
        funct3   = f;
        mem_addr = a;
        inst_num = n;
        load_phy = p;
        predict_load(a, f, n);
        exp_next.phy  = p;
        exp_next.inst = n;
        @(posedge clk);
        #1;
        memread = 1'b0;
        waited  = 0;
        while (!load_done_out && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!load_done_out) begin
            errors++;
            $display("timeout waiting for load_done_out after a load from %h", a);
        end
    endtask

    task automatic commit_op(input addr_t a, input inst_num_t n);
        memwrite_rob = 1'b1;
        mem_addr_rob = a;
        inst_num_rob = n;
        if (model_inst.exists(a) && model_inst[a] == n) begin
            model_data.delete(a);
            model_mask.delete(a);
            model_inst.delete(a);
        end
        exp_next.full = (model_mask.num() == DEPTH);
        @(posedge clk);
        #1;
        memwrite_rob = 1'b0;
    endtask

    task automatic flush_op(input logic by_mret);
        exception = !by_mret;
        mret_sig  = by_mret;
        model_data.delete();
        model_mask.delete();
        model_inst.delete();
        exp_next.flag = 1'b0;
        exp_next.full = 1'b0;
        @(posedge clk);
        #1;
        exception = 1'b0;
        mret_sig  = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        @(posedge clk);
        #1;  // Let the last check fire
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %0d %s: FAILED", num, name);
        end else begin
            $display("test %0d %s: passed", num, name);
        end
        errors_before = errors;
    endtask

    initial begin
        addr_t addrs [DEPTH];
        addr_t a;
        int    tries;
        int    waited;
        clk           = 1'b0;
        reset         = 1'b1;
        exception     = 1'b0;
        mret_sig      = 1'b0;
        memwrite      = 1'b0;
        memread       = 1'b0;
        funct3        = '0;
        load_phy      = '0;
        inst_num      = '0;
        mem_addr      = '0;
        mem_data      = '0;
        memwrite_rob  = 1'b0;
        mem_addr_rob  = '0;
        inst_num_rob  = '0;
        exp_next      = '0;
        errors        = 0;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        seed          = 50;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        store_op(32'h100, 3'd2, 32'h1234_5678, 10);
        load_op(32'h100, 3'd2, 11, 8'd5);
        end_test(1, "reset and word forwarding");

        store_op(32'h200, 3'd0, 32'hAAAA_AA80, 20);  // Upper bytes must be dropped
        load_op(32'h200, 3'd0, 21, 8'd6);
        load_op(32'h200, 3'd1, 21, 8'd7);
        load_op(32'h200, 3'd2, 21, 8'd8);
        store_op(32'h204, 3'd1, 32'h0000_BEEF, 22);
        load_op(32'h204, 3'd2, 23, 8'd9);
        end_test(2, "partial coverage");

        store_op(32'h300, 3'd2, 32'hAABB_CCDD, 30);
        store_op(32'h300, 3'd1, 32'h0000_1122, 31);
        load_op(32'h300, 3'd2, 32, 8'd10);
        store_op(32'h304, 3'd2, 32'h5566_7788, 40);
        store_op(32'h304, 3'd1, 32'h0000_9999, 35);  // Older halfword loses
        load_op(32'h304, 3'd2, 41, 8'd11);
        end_test(3, "merge by age");

        commit_op(32'h300, 31);
        load_op(32'h300, 3'd2, 42, 8'd12);
        commit_op(32'h304, 35);
        load_op(32'h304, 3'd2, 43, 8'd13);
        end_test(4, "commit");

        store_op(32'h400, 3'd2, 32'hCAFE_F00D, 60);
        load_op(32'h400, 3'd2, 55, 8'd14);
        load_op(32'h100, 3'd2, 70, 8'd15);
        flush_op(1'b0);
        load_op(32'h400, 3'd2, 71, 8'd16);
        load_op(32'h100, 3'd2, 72, 8'd17);
        store_op(32'h500, 3'd1, 32'h0000_8001, 80);
        load_op(32'h500, 3'd1, 75, 8'd18);
        flush_op(1'b1);
        load_op(32'h500, 3'd1, 81, 8'd19);
        end_test(5, "ordering violation and flush");

        for (int i = 0; i < DEPTH; i++) begin
            a     = addr_t'({$random(seed)}) & 32'hFFFF_FFFC;
            tries = 0;
            while (model_mask.exists(a) && tries < 16) begin
                a = addr_t'({$random(seed)}) & 32'hFFFF_FFFC;
                tries++;
            end
            addrs[i] = a;
            store_op(a, funct3_t'({$random(seed)} % 3), word_t'($random(seed)), 100 + i);
        end
        waited = 0;
        while (!sb_full && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!sb_full) begin
            errors++;
            $display("timeout waiting for sb_full after %0d stores", DEPTH);
        end
        commit_op(addrs[3], 103);
        for (int i = 0; i < DEPTH; i++) begin
            load_op(addrs[i], funct3_t'({$random(seed)} % 3), 200 + i, phy_t'(i + 1));
        end
        end_test(6, "capacity");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/rv_mem_pkg.sv
verilog/sb_pkg.sv
verilog/mem_req_decode.sv
verilog/store_buffer.sv
verilog/load_result.sv
verilog/lsu_store_top.sv
verification/tb_store_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_store_buffer -f tb.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
